//--- hw/sha256_macros.svh
// --------------------
// Shared constants for the SHA-256 accelerator
// Bus widths, register byte offsets and control bit positions
// Include in any file that decodes or drives the address map
// --------------------
`ifndef SHA256_MACROS_SVH
`define SHA256_MACROS_SVH

// Host bus widths
`define SHA256_DATA_WIDTH 32
`define SHA256_ADDR_WIDTH 8

// Register byte offsets
`define SHA256_NAME_ADDR 8'h00
`define SHA256_VERSION_ADDR 8'h04
`define SHA256_CTRL_ADDR 8'h10
`define SHA256_STATUS_ADDR 8'h18
// Sixteen block words, word 0 is the most significant
`define SHA256_BLOCK_BASE 8'h40
// Eight digest words, word 0 is H0
`define SHA256_DIGEST_BASE 8'h80
`define SHA256_INTR_STS_ADDR 8'hA0

// CTRL bits, MODE set selects SHA-256
`define SHA256_CTRL_INIT 0
`define SHA256_CTRL_NEXT 1
`define SHA256_CTRL_MODE 2
`define SHA256_CTRL_ZEROIZE 3

// STATUS bits
`define SHA256_STATUS_READY 0
`define SHA256_STATUS_VALID 1

`endif

//--- hw/sha256_reg_pkg.sv
// --------------------
// Register-side constants of the SHA-256 accelerator
// Identification words and interrupt status bit indices
// --------------------
`default_nettype none

package sha256_reg_pkg;

  // Identification, "SHA2" in ASCII
  localparam logic [31:0] core_name = 32'h5348_4132;
  // Major 1, minor 0
  localparam logic [31:0] core_version = 32'h0001_0000;

  // Interrupt status register bits
  // Error set by a write with INIT and NEXT together
  localparam int unsigned intr_err_bit = 0;
  // Done set on every completed block
  localparam int unsigned intr_done_bit = 1;

endpackage

`default_nettype wire

//--- hw/sha256_core_pkg.sv
// --------------------
// SHA-256 algorithm constants and round functions
// Used by the compression engine only
// --------------------
`default_nettype none

package sha256_core_pkg;

  // Round constants K0..K63, index 0 first
  localparam logic [0:63][31:0] k_table = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash values, H0 at index 0
  localparam logic [0:7][31:0] iv_224 = {
    32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
    32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4
  };
  localparam logic [0:7][31:0] iv_256 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  function automatic logic [31:0] round_k(input logic [5:0] t);
    return k_table[t];
  endfunction

  // Rotate right, n is always a constant here
  function automatic logic [31:0] rotr(input logic [31:0] x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // Compression functions
  function automatic logic [31:0] big_sigma0(input logic [31:0] x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic logic [31:0] big_sigma1(input logic [31:0] x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  // Message schedule functions
  function automatic logic [31:0] small_sigma0(input logic [31:0] x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [31:0] small_sigma1(input logic [31:0] x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  function automatic logic [31:0] ch(input logic [31:0] x, input logic [31:0] y,
                                     input logic [31:0] z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic logic [31:0] maj(input logic [31:0] x, input logic [31:0] y,
                                      input logic [31:0] z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

endpackage

`default_nettype wire

//--- hw/sha256_core.sv
// --------------------
// Iterative SHA-256 compression engine, one round per clock
// Command edge loads, 64 rounds follow, then one add-back cycle
// ready and digest_valid rise together on the 66th edge
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sha256_core (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         zeroize,
  input  logic         init_cmd,
  input  logic         next_cmd,
  input  logic         mode,
  input  logic [511:0] block_msg,
  output logic         ready,
  output logic [255:0] digest,
  output logic         digest_valid
);

  // FSM encodings
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_round = 2'd1;
  localparam logic [1:0] st_add   = 2'd2;

  logic [1:0]        state;
  logic [5:0]        round_ctr;
  logic              ready_q;
  logic              valid_q;
  // Hash state H0..H7 and working variables a..h
  logic [0:7][31:0]  hash_q;
  logic [0:7][31:0]  work_q;
  // Rolling schedule window, w_q[0] is W for the current round
  logic [0:15][31:0] w_q;

  logic              start;
  logic [0:7][31:0]  init_iv;
  logic [31:0]       t1;
  logic [31:0]       t2;
  logic [31:0]       w_next;
  logic [0:7][31:0]  work_next;

  // Commands count only while idle
  assign start   = ready_q && (init_cmd || next_cmd);
  assign init_iv = mode ? sha256_core_pkg::iv_256 : sha256_core_pkg::iv_224;

  // --------------------
  // Round datapath
  // --------------------
  always_comb begin
    t1 = work_q[7] + sha256_core_pkg::big_sigma1(work_q[4])
       + sha256_core_pkg::ch(work_q[4], work_q[5], work_q[6])
       + sha256_core_pkg::round_k(round_ctr) + w_q[0];
    t2 = sha256_core_pkg::big_sigma0(work_q[0])
       + sha256_core_pkg::maj(work_q[0], work_q[1], work_q[2]);
    // a gets T1+T2, e gets d+T1, the rest shift down
    work_next = {t1 + t2, work_q[0], work_q[1], work_q[2],
                 work_q[3] + t1, work_q[4], work_q[5], work_q[6]};
    // W(t+16) from the window
    w_next = sha256_core_pkg::small_sigma1(w_q[14]) + w_q[9]
           + sha256_core_pkg::small_sigma0(w_q[1]) + w_q[0];
  end

  // Working variables and schedule window
  always_ff @(posedge clk) begin
    if (zeroize) begin
      work_q <= '0;
      w_q    <= '0;
    end else if (start) begin
      // First block starts from the IV, later blocks from the digest
      work_q <= init_cmd ? init_iv : hash_q;
      w_q    <= block_msg;
    end else if (state == st_round) begin
      work_q <= work_next;
      w_q    <= {w_q[1:15], w_next};
    end
  end

  // --------------------
  // Control FSM and hash state
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= st_idle;
      round_ctr <= '0;
      ready_q   <= 1'b1;
      valid_q   <= 1'b0;
      hash_q    <= '0;
    end else if (zeroize) begin
      // Abort and wipe, back to ready
      state     <= st_idle;
      round_ctr <= '0;
      ready_q   <= 1'b1;
      valid_q   <= 1'b0;
      hash_q    <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_round;
            round_ctr <= '0;
            ready_q   <= 1'b0;
            valid_q   <= 1'b0;
            if (init_cmd) begin
              hash_q <= init_iv;
            end
          end
        end
        st_round: begin
          round_ctr <= round_ctr + 6'd1;
          // Round 63 is the last
          if (round_ctr == 6'd63) begin
            state <= st_add;
          end
        end
        st_add: begin
          for (int i = 0; i < 8; i++) begin
            hash_q[i] <= hash_q[i] + work_q[i];
          end
          state   <= st_idle;
          ready_q <= 1'b1;
          valid_q <= 1'b1;
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign ready        = ready_q;
  assign digest_valid = valid_q;
  // H0 lands in the top word
  assign digest       = hash_q;

endmodule

`default_nettype wire

//--- hw/sha256_regs.sv
// --------------------
// Host register block of the SHA-256 accelerator
// Decodes the strobe bus, holds block, control and digest registers,
// issues core commands and drives status, interrupts and err
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "sha256_macros.svh"

module sha256_regs (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          cs,
  input  logic                          we,
  input  logic [`SHA256_ADDR_WIDTH-1:0] address,
  input  logic [`SHA256_DATA_WIDTH-1:0] write_data,
  output logic [`SHA256_DATA_WIDTH-1:0] read_data,
  output logic                          err,
  output logic                          error_intr,
  output logic                          notif_intr,
  output logic                          init_cmd,
  output logic                          next_cmd,
  output logic                          mode,
  output logic                          zeroize,
  output logic [511:0]                  block_msg,
  input  logic                          ready,
  input  logic [255:0]                  digest,
  input  logic                          digest_valid
);

  logic [0:15][31:0] block_q;
  logic [0:7][31:0]  digest_q;
  logic              mode_q;
  logic              valid_q;
  logic              core_valid_d;
  logic              err_sts;
  logic              done_sts;

  // Address decode
  logic              is_name;
  logic              is_version;
  logic              is_ctrl;
  logic              is_status;
  logic              is_intr;
  logic              in_block;
  logic              in_digest;
  logic              mapped;
  logic [3:0]        block_idx;
  logic [2:0]        digest_idx;

  logic              ctrl_wr;
  logic              bad_cmd;
  logic              valid_rise;
  logic [255:0]      digest_masked;
  logic [31:0]       rdata;

  assign is_name    = address == `SHA256_NAME_ADDR;
  assign is_version = address == `SHA256_VERSION_ADDR;
  assign is_ctrl    = address == `SHA256_CTRL_ADDR;
  assign is_status  = address == `SHA256_STATUS_ADDR;
  assign is_intr    = address == `SHA256_INTR_STS_ADDR;
  // Word aligned windows, 0x40-0x7C and 0x80-0x9C
  assign in_block   = (address & 8'hC3) == `SHA256_BLOCK_BASE;
  assign in_digest  = (address & 8'hE3) == `SHA256_DIGEST_BASE;
  assign block_idx  = address[5:2];
  assign digest_idx = address[4:2];
  assign mapped     = is_name | is_version | is_ctrl | is_status | is_intr
                    | in_block | in_digest;

  // --------------------
  // Core commands
  // --------------------
  assign ctrl_wr = cs && we && is_ctrl;
  // INIT and NEXT together is an error and starts nothing
  assign bad_cmd = ctrl_wr && write_data[`SHA256_CTRL_INIT] && write_data[`SHA256_CTRL_NEXT];
  assign init_cmd = ctrl_wr && ready && write_data[`SHA256_CTRL_INIT]
                  && !write_data[`SHA256_CTRL_NEXT];
  assign next_cmd = ctrl_wr && ready && write_data[`SHA256_CTRL_NEXT]
                  && !write_data[`SHA256_CTRL_INIT];
  assign zeroize  = ctrl_wr && write_data[`SHA256_CTRL_ZEROIZE];
  // Core samples mode with the command, same write
  assign mode      = ctrl_wr ? write_data[`SHA256_CTRL_MODE] : mode_q;
  assign block_msg = block_q;

  // Digest capture on the rising edge of the core valid
  assign valid_rise    = digest_valid && !core_valid_d;
  // SHA-224 drops H7
  assign digest_masked = mode_q ? digest : {digest[255:32], 32'h0};

  // Block words
  always_ff @(posedge clk) begin
    if (zeroize) begin
      block_q <= '0;
    end else if (cs && we && in_block) begin
      block_q[block_idx] <= write_data;
    end
  end

  // --------------------
  // Control and status
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mode_q       <= 1'b0;
      valid_q      <= 1'b0;
      core_valid_d <= 1'b0;
      digest_q     <= '0;
    end else begin
      core_valid_d <= digest_valid;
      // Mode only follows the host while the core is idle
      if (ctrl_wr && ready) begin
        mode_q <= write_data[`SHA256_CTRL_MODE];
      end
      if (zeroize) begin
        digest_q <= '0;
        valid_q  <= 1'b0;
      end else begin
        if (valid_rise) begin
          digest_q <= digest_masked;
          valid_q  <= 1'b1;
        end
        // A new block makes the captured digest stale
        if (init_cmd || next_cmd) begin
          valid_q <= 1'b0;
        end
      end
    end
  end

  // Sticky interrupt status, set wins over write-one-to-clear
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      err_sts  <= 1'b0;
      done_sts <= 1'b0;
    end else begin
      if (bad_cmd) begin
        err_sts <= 1'b1;
      end else if (cs && we && is_intr && write_data[sha256_reg_pkg::intr_err_bit]) begin
        err_sts <= 1'b0;
      end
      if (valid_rise && !zeroize) begin
        done_sts <= 1'b1;
      end else if (cs && we && is_intr && write_data[sha256_reg_pkg::intr_done_bit]) begin
        done_sts <= 1'b0;
      end
    end
  end

  assign error_intr = err_sts;
  assign notif_intr = done_sts;

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    rdata = '0;
    if (is_name) begin
      rdata = sha256_reg_pkg::core_name;
    end else if (is_version) begin
      rdata = sha256_reg_pkg::core_version;
    end else if (is_ctrl) begin
      rdata[`SHA256_CTRL_MODE] = mode_q;
    end else if (is_status) begin
      rdata[`SHA256_STATUS_READY] = ready;
      rdata[`SHA256_STATUS_VALID] = valid_q;
    end else if (is_intr) begin
      rdata[sha256_reg_pkg::intr_err_bit]  = err_sts;
      rdata[sha256_reg_pkg::intr_done_bit] = done_sts;
    end else if (in_block) begin
      rdata = block_q[block_idx];
    end else if (in_digest) begin
      rdata = digest_q[digest_idx];
    end
  end

  // One cycle read latency, err for reads and writes alike
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_data <= '0;
      err       <= 1'b0;
    end else begin
      read_data <= (cs && !we) ? rdata : '0;
      err       <= cs && !mapped;
    end
  end

endmodule

`default_nettype wire

//--- hw/sha256.sv
// --------------------
// SHA-256 accelerator top level
// Host strobe bus in, register block and compression core inside
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "sha256_macros.svh"

module sha256 (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          cs,
  input  logic                          we,
  input  logic [`SHA256_ADDR_WIDTH-1:0] address,
  input  logic [`SHA256_DATA_WIDTH-1:0] write_data,
  output logic [`SHA256_DATA_WIDTH-1:0] read_data,
  output logic                          err,
  output logic                          error_intr,
  output logic                          notif_intr
);

  // Register block to core
  logic         init_cmd;
  logic         next_cmd;
  logic         mode;
  logic         zeroize;
  logic [511:0] block_msg;
  // Core back to register block
  logic         ready;
  logic [255:0] digest;
  logic         digest_valid;

  sha256_regs regs_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (cs),
    .we           (we),
    .address      (address),
    .write_data   (write_data),
    .read_data    (read_data),
    .err          (err),
    .error_intr   (error_intr),
    .notif_intr   (notif_intr),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .mode         (mode),
    .zeroize      (zeroize),
    .block_msg    (block_msg),
    .ready        (ready),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

  sha256_core core_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .mode         (mode),
    .block_msg    (block_msg),
    .ready        (ready),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

endmodule

`default_nettype wire

//--- dv/sha256_asserts.sv
// --------------------
// Concurrent checks for the SHA-256 accelerator, bound to the top level
// Compares bus responses with the expectations that the testbench publishes
// and checks reset values, err, interrupts and the done notification
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "sha256_macros.svh"

module sha256_asserts (
  input logic                          clk,
  input logic                          reset_n,
  input logic                          cs,
  input logic                          we,
  input logic [`SHA256_ADDR_WIDTH-1:0] address,
  input logic [`SHA256_DATA_WIDTH-1:0] write_data,
  input logic [`SHA256_DATA_WIDTH-1:0] read_data,
  input logic                          err,
  input logic                          error_intr,
  input logic                          notif_intr,
  input logic                          ready,
  input logic                          digest_valid,
  // Expectations from the testbench
  input logic                          rd_check,
  input logic [`SHA256_DATA_WIDTH-1:0] rd_expected,
  input logic                          err_expected,
  input logic                          intr_check,
  input logic                          error_expected,
  input logic                          notif_expected
);

  // Failure counts, one per check
  int unsigned n_reset = 0;
  int unsigned n_read = 0;
  int unsigned n_err = 0;
  int unsigned n_bad_cmd = 0;
  int unsigned n_done = 0;
  int unsigned n_intr = 0;
  int unsigned fails;

  logic [`SHA256_DATA_WIDTH-1:0] rd_expected_q;
  logic                          err_expected_q;
  logic                          both_cmds;

  assign fails = n_reset + n_read + n_err + n_bad_cmd + n_done + n_intr;

  // Expectations follow the strobe by one cycle, like read_data and err
  always_ff @(posedge clk) begin
    rd_expected_q  <= rd_expected;
    err_expected_q <= err_expected;
  end

  // CTRL write with INIT and NEXT together
  assign both_cmds = cs && we && (address == `SHA256_CTRL_ADDR)
                   && write_data[`SHA256_CTRL_INIT] && write_data[`SHA256_CTRL_NEXT];

  // --------------------
  // Reset and bus response
  // --------------------
  reset_values: assert property (@(posedge clk) $rose(reset_n) |->
      (!err && !error_intr && !notif_intr && read_data == '0 && ready && !digest_valid))
    else begin
      n_reset = n_reset + 1;
      $error("[FAIL] %0t outputs are not at their reset values", $time);
    end

  // One cycle read latency
  read_value: assert property (@(posedge clk) disable iff (!reset_n)
      (cs && !we && rd_check) |=> (read_data == rd_expected_q))
    else begin
      n_read = n_read + 1;
      $error("[FAIL] %0t read_data %h, expected %h", $time,
             $sampled(read_data), $sampled(rd_expected_q));
    end

  // err pulses only for unmapped addresses, reads and writes alike
  err_response: assert property (@(posedge clk) disable iff (!reset_n)
      cs |=> (err == err_expected_q))
    else begin
      n_err = n_err + 1;
      $error("[FAIL] %0t err is %b, expected %b", $time,
             $sampled(err), $sampled(err_expected_q));
    end

  // --------------------
  // Interrupts
  // --------------------
  // Bad command raises the error and starts nothing
  bad_command: assert property (@(posedge clk) disable iff (!reset_n)
      both_cmds |=> (error_intr && ready))
    else begin
      n_bad_cmd = n_bad_cmd + 1;
      $error("[FAIL] %0t INIT with NEXT did not raise error_intr or started the core", $time);
    end

  // Completion comes with ready and raises the notification
  done_notify: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(digest_valid) |-> ready ##1 notif_intr)
    else begin
      n_done = n_done + 1;
      $error("[FAIL] %0t completed hash without ready or notif_intr", $time);
    end

  intr_levels: assert property (@(posedge clk) disable iff (!reset_n)
      intr_check |-> (error_intr == error_expected && notif_intr == notif_expected))
    else begin
      n_intr = n_intr + 1;
      $error("[FAIL] %0t interrupts %b/%b, expected %b/%b", $time,
             $sampled(error_intr), $sampled(notif_intr),
             $sampled(error_expected), $sampled(notif_expected));
    end

endmodule

`default_nettype wire

//--- dv/tb_sha256.sv
// --------------------
// Testbench for the SHA-256 accelerator
// Drives the host bus through known-answer hashes, errors and zeroize
// Publishes expected read data and interrupt levels for the bound checks
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "sha256_macros.svh"

module tb_sha256;

  localparam int poll_limit = 100;

  // CTRL and interrupt status words
  localparam logic [31:0] ctrl_init    = 32'd1 << `SHA256_CTRL_INIT;
  localparam logic [31:0] ctrl_next    = 32'd1 << `SHA256_CTRL_NEXT;
  localparam logic [31:0] ctrl_mode    = 32'd1 << `SHA256_CTRL_MODE;
  localparam logic [31:0] ctrl_zeroize = 32'd1 << `SHA256_CTRL_ZEROIZE;
  localparam logic [31:0] sts_ready    = 32'd1 << `SHA256_STATUS_READY;
  localparam logic [31:0] sts_valid    = 32'd1 << `SHA256_STATUS_VALID;
  localparam logic [31:0] intr_err     = 32'd1 << sha256_reg_pkg::intr_err_bit;
  localparam logic [31:0] intr_done    = 32'd1 << sha256_reg_pkg::intr_done_bit;

  // Padded "abc" in one block
  localparam logic [0:15][31:0] blk_abc = {
    32'h61626380, 32'h00000000, 32'h00000000, 32'h00000000,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000018
  };
  // 448-bit message over two blocks
  localparam logic [0:15][31:0] blk_long_1 = {
    32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
    32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
    32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
    32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
  };
  localparam logic [0:15][31:0] blk_long_2 = {
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h000001c0
  };

  // Published digests
  localparam logic [0:7][31:0] dig_abc_256 = {
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };
  // SHA-224 word 7 reads zero
  localparam logic [0:7][31:0] dig_abc_224 = {
    32'h23097d22, 32'h3405d822, 32'h8642a477, 32'hbda255b3,
    32'h2aadbce4, 32'hbda0b3f7, 32'he36c9da7, 32'h00000000
  };
  localparam logic [0:7][31:0] dig_long_256 = {
    32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
    32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
  };

  logic                          clk = 1'b0;
  logic                          reset_n;
  logic                          cs;
  logic                          we;
  logic [`SHA256_ADDR_WIDTH-1:0] address;
  logic [`SHA256_DATA_WIDTH-1:0] write_data;
  logic [`SHA256_DATA_WIDTH-1:0] read_data;
  logic                          err;
  logic                          error_intr;
  logic                          notif_intr;

  // Published for the assertions
  logic                          exp_rd_check;
  logic [`SHA256_DATA_WIDTH-1:0] exp_rd_data;
  logic                          exp_err;
  logic                          intr_check;
  logic                          exp_error_intr;
  logic                          exp_notif_intr;

  int unsigned                   timeouts;

  always #2 clk = ~clk;

  sha256 sha256_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .err        (err),
    .error_intr (error_intr),
    .notif_intr (notif_intr)
  );

  bind sha256 sha256_asserts asserts_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .cs             (cs),
    .we             (we),
    .address        (address),
    .write_data     (write_data),
    .read_data      (read_data),
    .err            (err),
    .error_intr     (error_intr),
    .notif_intr     (notif_intr),
    .ready          (ready),
    .digest_valid   (digest_valid),
    .rd_check       (tb_sha256.exp_rd_check),
    .rd_expected    (tb_sha256.exp_rd_data),
    .err_expected   (tb_sha256.exp_err),
    .intr_check     (tb_sha256.intr_check),
    .error_expected (tb_sha256.exp_error_intr),
    .notif_expected (tb_sha256.exp_notif_intr)
  );

  // --------------------
  // Bus tasks
  // --------------------
  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b1;
    address    <= addr;
    write_data <= data;
    exp_err    <= 1'b0;
    @(posedge clk);
    cs <= 1'b0;
    we <= 1'b0;
  endtask

  // Read with optional expectation
  // Data is sampled at the falling edge
  task automatic bus_read(input logic [7:0] addr, input logic check, input logic [31:0] expd,
                          input logic bad, output logic [31:0] data);
    @(posedge clk);
    cs           <= 1'b1;
    we           <= 1'b0;
    address      <= addr;
    exp_rd_check <= check;
    exp_rd_data  <= expd;
    exp_err      <= bad;
    @(posedge clk);
    cs           <= 1'b0;
    exp_rd_check <= 1'b0;
    exp_err      <= 1'b0;
    @(negedge clk);
    data = read_data;
  endtask

  task automatic expect_read(input logic [7:0] addr, input logic [31:0] expd);
    logic [31:0] data;
    bus_read(addr, 1'b1, expd, 1'b0, data);
  endtask

  // Poll STATUS until READY or the poll limit
  task automatic wait_ready();
    logic [31:0] data;
    int          polls;
    data  = '0;
    polls = 0;
    while (!data[`SHA256_STATUS_READY] && polls < poll_limit) begin
      bus_read(`SHA256_STATUS_ADDR, 1'b0, '0, 1'b0, data);
      polls++;
    end
    if (!data[`SHA256_STATUS_READY]) begin
      $display("Timeout: core did not return to ready within %0d status polls", polls);
      timeouts++;
    end
  endtask

  task automatic load_block(input logic [0:15][31:0] blk);
    for (int i = 0; i < 16; i++) begin
      reg_write(8'(`SHA256_BLOCK_BASE + 4 * i), blk[i]);
    end
  endtask

  task automatic check_digest(input logic [0:7][31:0] dig);
    for (int i = 0; i < 8; i++) begin
      expect_read(8'(`SHA256_DIGEST_BASE + 4 * i), dig[i]);
    end
  endtask

  // One-cycle marker for the interrupt level check
  task automatic expect_intr(input logic error_level, input logic notif_level);
    @(posedge clk);
    intr_check     <= 1'b1;
    exp_error_intr <= error_level;
    exp_notif_intr <= notif_level;
    @(posedge clk);
    intr_check <= 1'b0;
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    logic [31:0] data;
    reset_n        = 1'b0;
    cs             = 1'b0;
    we             = 1'b0;
    address        = '0;
    write_data     = '0;
    exp_rd_check   = 1'b0;
    exp_rd_data    = '0;
    exp_err        = 1'b0;
    intr_check     = 1'b0;
    exp_error_intr = 1'b0;
    exp_notif_intr = 1'b0;
    timeouts       = 0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;

    // Identification and idle status
    expect_read(`SHA256_NAME_ADDR, sha256_reg_pkg::core_name);
    expect_read(`SHA256_VERSION_ADDR, sha256_reg_pkg::core_version);
    expect_read(`SHA256_STATUS_ADDR, sts_ready);
    expect_intr(1'b0, 1'b0);

    // SHA-256 of "abc"
    load_block(blk_abc);
    reg_write(`SHA256_CTRL_ADDR, ctrl_init | ctrl_mode);
    wait_ready();
    expect_read(`SHA256_STATUS_ADDR, sts_ready | sts_valid);
    check_digest(dig_abc_256);
    expect_intr(1'b0, 1'b1);

    // SHA-224 of the same block
    reg_write(`SHA256_CTRL_ADDR, ctrl_init);
    wait_ready();
    check_digest(dig_abc_224);

    // Two blocks with INIT then NEXT
    load_block(blk_long_1);
    reg_write(`SHA256_CTRL_ADDR, ctrl_init | ctrl_mode);
    wait_ready();
    load_block(blk_long_2);
    reg_write(`SHA256_CTRL_ADDR, ctrl_next | ctrl_mode);
    wait_ready();
    check_digest(dig_long_256);

    // INIT and NEXT together leave the digest valid
    reg_write(`SHA256_CTRL_ADDR, ctrl_init | ctrl_next | ctrl_mode);
    expect_read(`SHA256_STATUS_ADDR, sts_ready | sts_valid);
    expect_intr(1'b1, 1'b1);
    expect_read(`SHA256_INTR_STS_ADDR, intr_err | intr_done);
    reg_write(`SHA256_INTR_STS_ADDR, intr_err);
    expect_intr(1'b0, 1'b1);
    reg_write(`SHA256_INTR_STS_ADDR, intr_done);
    expect_intr(1'b0, 1'b0);
    expect_read(`SHA256_INTR_STS_ADDR, '0);

    // Unmapped read
    bus_read(8'h30, 1'b1, '0, 1'b1, data);
    // Nonzero pattern in every block word so that each clear is visible
    for (int i = 0; i < 16; i++) begin
      reg_write(8'(`SHA256_BLOCK_BASE + 4 * i),
                32'hA5A5_0000 | 32'(`SHA256_BLOCK_BASE + 4 * i));
    end
    // Zeroize wipes block and digest
    reg_write(`SHA256_CTRL_ADDR, ctrl_zeroize);
    check_digest('0);
    for (int i = 0; i < 16; i++) begin
      expect_read(8'(`SHA256_BLOCK_BASE + 4 * i), '0);
    end
    expect_read(`SHA256_STATUS_ADDR, sts_ready);

    repeat (4) @(posedge clk);
    $display("Errors: %0d assertion failures, %0d timeouts",
             sha256_i.asserts_i.fails, timeouts);
    if (sha256_i.asserts_i.fails == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/sha256_reg_pkg.sv
hw/sha256_core_pkg.sv
hw/sha256_core.sv
hw/sha256_regs.sv
hw/sha256.sv
dv/sha256_asserts.sv
dv/tb_sha256.sv

//--- Makefile
# Verilator build and run of the SHA-256 accelerator testbench
BIN := obj_dir/Vtb_sha256

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): compile.f hw/*.sv hw/*.svh dv/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_sha256 -f compile.f -o Vtb_sha256

# Status comes from grep, so a missing pass line fails the target
run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 | tee /dev/stderr | grep -qF "Result: PASSED"

clean:
	rm -rf obj_dir
